// File: hdl/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// wishbone side
`define EE_WB_AW 2
`define EE_WB_DW 8

// eeprom byte address, 2 Kbyte
`define EE_MEM_AW 11

`define EE_BIT_CLKS 4      // clk cycles per scl bit, one per quarter
`define EE_DEV_TYPE 4'b1010

// register offsets
`define EE_REG_ADDR_LO 2'd0
`define EE_REG_ADDR_HI 2'd1
`define EE_REG_DATA    2'd2
`define EE_REG_CTRL    2'd3

`endif

// File: hdl/ee_bus_pkg.sv
`default_nettype none

package ee_bus_pkg;

    // sequencer to bit engine
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_START,      // also used for repeated start
        CMD_STOP,
        CMD_WRITE_BYTE,
        CMD_READ_BYTE
    } bit_cmd_t;

    typedef enum logic [3:0] {
        PH_IDLE,
        PH_START,
        PH_CTRL_WR,
        PH_ADDR,
        PH_DATA_WR,
        PH_RESTART,
        PH_CTRL_RD,
        PH_DATA_RD,
        PH_STOP,
        PH_DONE
    } seq_phase_t;

endpackage

`default_nettype wire

// File: hdl/ee_reg_pkg.sv
`include "eeprom_defines.svh"
`default_nettype none

package ee_reg_pkg;

    typedef enum logic [`EE_WB_AW-1:0] {
        SEL_ADDR_LO = `EE_REG_ADDR_LO,
        SEL_ADDR_HI = `EE_REG_ADDR_HI,
        SEL_DATA    = `EE_REG_DATA,
        SEL_CTRL    = `EE_REG_CTRL
    } reg_sel_t;

    // CTRL bit positions as written
    typedef enum int unsigned {
        GO_WRITE = 0,
        GO_READ  = 1
    } ctrl_bit_t;

    // CTRL bit positions as read back
    typedef enum int unsigned {
        BUSY = 0,
        DONE = 1,
        NACK = 2
    } stat_bit_t;

endpackage

`default_nettype wire

// File: hdl/ee_regs.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_regs
    import ee_reg_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`EE_WB_AW-1:0]  wb_adr,
    input  logic [`EE_WB_DW-1:0]  wb_dat_w,
    output logic [`EE_WB_DW-1:0]  wb_dat_r,
    output logic                  wb_ack,
    output logic                  start_wr,
    output logic                  start_rd,
    output logic [`EE_MEM_AW-1:0] mem_addr,
    output logic [7:0]            wr_data,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  nack,
    input  logic [7:0]            rd_data
);

    reg_sel_t             sel;
    logic                 ack_q;
    logic                 wr_acc;
    logic                 go;
    logic [7:0]           addr_lo;
    logic [2:0]           addr_hi;
    logic [7:0]           data_q;
    logic                 done_q;
    logic                 nack_q;
    logic                 last_rd;    // transaction in flight is a read
    logic [`EE_WB_DW-1:0] status;

    assign sel    = reg_sel_t'(wb_adr);
    assign wb_ack = ack_q & wb_cyc & wb_stb;
    assign wr_acc = wb_ack & wb_we;

    // commands land on the ack cycle, dropped while busy
    assign go       = wr_acc && (sel == SEL_CTRL) && !busy;
    assign start_wr = go & wb_dat_w[GO_WRITE];
    assign start_rd = go & wb_dat_w[GO_READ] & ~wb_dat_w[GO_WRITE];   // write wins

    assign mem_addr = {addr_hi, addr_lo};
    assign wr_data  = data_q;

    always_comb
    begin
        status       = '0;
        status[BUSY] = busy;
        status[DONE] = done_q;
        status[NACK] = nack_q;
    end

    always_comb
    begin
        case (sel)
            SEL_ADDR_LO: wb_dat_r = addr_lo;
            SEL_ADDR_HI: wb_dat_r = {{(`EE_WB_DW - 3){1'b0}}, addr_hi};
            SEL_DATA:    wb_dat_r = data_q;
            default:     wb_dat_r = status;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ack_q   <= 1'b0;
            addr_lo <= '0;
            addr_hi <= '0;
            data_q  <= '0;
            done_q  <= 1'b0;
            nack_q  <= 1'b0;
            last_rd <= 1'b0;
        end
        else
        begin
            ack_q <= wb_cyc & wb_stb & ~ack_q;    // single cycle ack
            if (wr_acc)
            begin
                case (sel)
                    SEL_ADDR_LO: addr_lo <= wb_dat_w[7:0];
                    SEL_ADDR_HI: addr_hi <= wb_dat_w[2:0];
                    SEL_DATA:    data_q  <= wb_dat_w[7:0];
                    default: ;
                endcase
            end
            if (start_wr || start_rd)
            begin
                done_q  <= 1'b0;
                nack_q  <= 1'b0;
                last_rd <= start_rd;
            end
            if (done)
            begin
                done_q <= 1'b1;
                nack_q <= nack;
                if (last_rd && !nack)
                    data_q <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ee_xfer_seq.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_xfer_seq
    import ee_bus_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  start_wr,
    input  logic                  start_rd,
    input  logic [`EE_MEM_AW-1:0] mem_addr,
    input  logic [7:0]            wr_data,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic [7:0]            rd_data,
    output bit_cmd_t              cmd,
    output logic                  cmd_valid,
    output logic [7:0]            tx_byte,
    input  logic                  cmd_done,
    input  logic [7:0]            rx_byte,
    input  logic                  ack_seen
);

    seq_phase_t            phase;
    logic                  is_rd;
    logic                  wait_q;     // command issued, engine running
    logic                  nack_q;
    logic                  byte_wr;
    logic [`EE_MEM_AW-1:0] addr_q;
    logic [7:0]            data_q;
    logic [7:0]            rd_q;
    logic [6:0]            ctrl_hi;

    // device nibble plus block select bits
    assign ctrl_hi = {`EE_DEV_TYPE, addr_q[`EE_MEM_AW-1 -: 3]};

    assign byte_wr = (phase == PH_CTRL_WR) || (phase == PH_ADDR) ||
                     (phase == PH_DATA_WR) || (phase == PH_CTRL_RD);

    assign busy      = (phase != PH_IDLE);
    assign done      = (phase == PH_DONE);
    assign nack      = nack_q;
    assign rd_data   = rd_q;
    assign cmd_valid = !wait_q && (phase != PH_IDLE) && (phase != PH_DONE);

    always_comb
    begin
        cmd     = CMD_NONE;
        tx_byte = 8'h00;
        case (phase)
            PH_START,
            PH_RESTART: cmd = CMD_START;
            PH_CTRL_WR:
            begin
                cmd     = CMD_WRITE_BYTE;
                tx_byte = {ctrl_hi, 1'b0};
            end
            PH_ADDR:
            begin
                cmd     = CMD_WRITE_BYTE;
                tx_byte = addr_q[7:0];
            end
            PH_DATA_WR:
            begin
                cmd     = CMD_WRITE_BYTE;
                tx_byte = data_q;
            end
            PH_CTRL_RD:
            begin
                cmd     = CMD_WRITE_BYTE;
                tx_byte = {ctrl_hi, 1'b1};
            end
            PH_DATA_RD: cmd = CMD_READ_BYTE;
            PH_STOP:    cmd = CMD_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase  <= PH_IDLE;
            is_rd  <= 1'b0;
            wait_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else if (phase == PH_IDLE)
        begin
            if (start_wr || start_rd)
            begin
                phase  <= PH_START;
                is_rd  <= ~start_wr;
                nack_q <= 1'b0;
            end
        end
        else if (phase == PH_DONE)
            phase <= PH_IDLE;
        else if (cmd_valid)
            wait_q <= 1'b1;
        else if (cmd_done)
        begin
            wait_q <= 1'b0;
            if (byte_wr && !ack_seen)
            begin
                nack_q <= 1'b1;   // no slave ack, bail out
                phase  <= PH_STOP;
            end
            else
            begin
                case (phase)
                    PH_START:   phase <= PH_CTRL_WR;
                    PH_CTRL_WR: phase <= PH_ADDR;
                    PH_ADDR:    phase <= is_rd ? PH_RESTART : PH_DATA_WR;
                    PH_RESTART: phase <= PH_CTRL_RD;
                    PH_CTRL_RD: phase <= PH_DATA_RD;
                    PH_STOP:    phase <= PH_DONE;
                    default:    phase <= PH_STOP;   // data_wr, data_rd
                endcase
            end
        end
    end

    // payload, captured at start and after the read byte
    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && (start_wr || start_rd))
        begin
            addr_q <= mem_addr;
            data_q <= wr_data;
        end
        if (phase == PH_DATA_RD && cmd_done)
            rd_q <= rx_byte;
    end

endmodule

`default_nettype wire

// File: hdl/ee_bit_engine.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_bit_engine
    import ee_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bit_cmd_t   cmd,
    input  logic       cmd_valid,
    input  logic [7:0] tx_byte,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       ack_seen,
    output logic       scl,
    output logic       sda_o,
    output logic       sda_oe,
    input  logic       sda_i
);

    localparam int QW = $clog2(`EE_BIT_CLKS);
    localparam logic [QW-1:0] Q_LAST   = QW'(`EE_BIT_CLKS - 1);
    localparam logic [QW-1:0] Q_SAMPLE = QW'(2);   // middle of scl high

    bit_cmd_t      cmd_q;
    logic          active;
    logic [QW-1:0] qtr;
    logic [3:0]    bitn;
    logic [7:0]    shift_q;
    logic          scl_hold;
    logic          sda_hold;
    logic          oe_hold;
    logic          scl_hi;
    logic          ack_bit;
    logic          last_bit;

    assign scl_hi   = (qtr == QW'(1)) || (qtr == QW'(2));
    assign ack_bit  = (bitn == 4'd8);
    assign last_bit = (cmd_q == CMD_WRITE_BYTE || cmd_q == CMD_READ_BYTE) ? ack_bit : 1'b1;
    assign rx_byte  = shift_q;

    // line levels per quarter; idle keeps the last driven state
    always_comb
    begin
        scl    = scl_hold;
        sda_o  = sda_hold;
        sda_oe = oe_hold;
        if (active)
        begin
            case (cmd_q)
                CMD_START:
                begin
                    scl    = scl_hi;
                    sda_o  = (qtr < QW'(2));   // sda falls with scl high
                    sda_oe = 1'b1;
                end
                CMD_STOP:
                begin
                    scl    = (qtr != '0);
                    sda_o  = (qtr >= QW'(2));  // sda rises with scl high
                    sda_oe = (qtr != Q_LAST);  // release once stopped
                end
                CMD_WRITE_BYTE:
                begin
                    scl    = scl_hi;
                    sda_o  = ack_bit ? 1'b1 : shift_q[7];
                    sda_oe = !ack_bit;
                end
                CMD_READ_BYTE:
                begin
                    scl    = scl_hi;
                    sda_o  = 1'b1;     // master nack
                    sda_oe = ack_bit;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            cmd_q    <= CMD_NONE;
            qtr      <= '0;
            bitn     <= '0;
            cmd_done <= 1'b0;
            ack_seen <= 1'b0;
            scl_hold <= 1'b1;
            sda_hold <= 1'b1;
            oe_hold  <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid && cmd != CMD_NONE)
                begin
                    active <= 1'b1;
                    cmd_q  <= cmd;
                    qtr    <= '0;
                    bitn   <= '0;
                end
            end
            else
            begin
                scl_hold <= scl;
                sda_hold <= sda_o;
                oe_hold  <= sda_oe;
                if (cmd_q == CMD_WRITE_BYTE && ack_bit && qtr == Q_SAMPLE)
                    ack_seen <= ~sda_i;
                if (qtr == Q_LAST)
                begin
                    qtr  <= '0;
                    bitn <= bitn + 4'd1;
                    if (last_bit)
                    begin
                        active   <= 1'b0;
                        cmd_done <= 1'b1;
                    end
                end
                else
                    qtr <= qtr + QW'(1);
            end
        end
    end

    // shared shift register, msb first both ways
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
            shift_q <= tx_byte;
        else if (active && !ack_bit)
        begin
            if (cmd_q == CMD_READ_BYTE && qtr == Q_SAMPLE)
                shift_q <= {shift_q[6:0], sda_i};
            else if (cmd_q == CMD_WRITE_BYTE && qtr == Q_LAST)
                shift_q <= {shift_q[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: hdl/ee_ctrl_top.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_ctrl_top
    import ee_bus_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`EE_WB_AW-1:0] wb_adr,
    input  logic [`EE_WB_DW-1:0] wb_dat_w,
    output logic [`EE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack,
    output logic                 scl,
    output logic                 sda_o,
    output logic                 sda_oe,
    input  logic                 sda_i
);

    logic                  start_wr;
    logic                  start_rd;
    logic [`EE_MEM_AW-1:0] mem_addr;
    logic [7:0]            wr_data;
    logic                  busy;
    logic                  done;
    logic                  nack;
    logic [7:0]            rd_data;
    bit_cmd_t              cmd;
    logic                  cmd_valid;
    logic [7:0]            tx_byte;
    logic                  cmd_done;
    logic [7:0]            rx_byte;
    logic                  ack_seen;

    ee_regs i_ee_regs (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .start_wr (start_wr),
        .start_rd (start_rd),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .busy     (busy),
        .done     (done),
        .nack     (nack),
        .rd_data  (rd_data)
    );

    ee_xfer_seq i_ee_xfer_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .start_wr  (start_wr),
        .start_rd  (start_rd),
        .mem_addr  (mem_addr),
        .wr_data   (wr_data),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rd_data   (rd_data),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen)
    );

    ee_bit_engine i_ee_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen),
        .scl       (scl),
        .sda_o     (sda_o),
        .sda_oe    (sda_oe),
        .sda_i     (sda_i)
    );

endmodule

`default_nettype wire

// File: verif/ee_mem_model.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_mem_model (
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_low      // pulls the shared line low when set
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [0:2047];
    logic [7:0]  sh;
    logic [7:0]  out;
    logic [10:0] ptr;
    logic        active;
    logic        tx;          // slave sends the data byte
    logic        sent;
    int          cnt;
    int          byte_idx;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        sda_low  = 1'b0;
        active   = 1'b0;
        tx       = 1'b0;
        sent     = 1'b0;
        cnt      = 0;
        byte_idx = 0;
        sh       = 8'h00;
        out      = 8'hff;
        ptr      = '0;
    end

    // start, also repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1 && present)
        begin
            active   = 1'b1;
            tx       = 1'b0;
            sent     = 1'b0;
            cnt      = 0;
            byte_idx = 0;
            sda_low  = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b0;   // stop
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (cnt < 8 && !tx)
                sh = {sh[6:0], sda};
            cnt = cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (cnt == 8)
            begin
                if (tx)
                    sda_low = 1'b0;    // master acks or nacks
                else
                    take_byte();
            end
            else if (cnt == 9)
            begin
                cnt     = 0;
                sda_low = 1'b0;
                if (tx && !sent)
                begin
                    sent    = 1'b1;
                    sda_low = ~out[7];
                end
                else if (tx)
                    active = 1'b0;     // single byte read only
            end
            else if (tx && sent && cnt >= 1)
                sda_low = ~out[3'(7 - cnt)];
        end
    end

    task automatic take_byte();
        logic ackit;
        ackit = 1'b1;
        case (byte_idx)
            0:
            begin
                if (sh[7:4] == `EE_DEV_TYPE)
                begin
                    ptr[10:8] = sh[3:1];
                    if (sh[0])
                    begin
                        tx  = 1'b1;
                        out = mem[ptr];
                    end
                end
                else
                    ackit = 1'b0;
            end
            1: ptr[7:0] = sh;
            default: mem[ptr] = sh;
        endcase
        byte_idx = byte_idx + 1;
        sda_low  = ackit;
        if (!ackit)
            active = 1'b0;
    endtask

endmodule

`default_nettype wire

// File: verif/ee_checker.sv
`default_nettype none

module ee_checker (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_r,
    input  logic       wb_ack,
    input  logic       exp_en,
    input  logic [7:0] exp_data,
    input  logic [7:0] exp_mask,
    input  int         test_id,
    input  logic       test_end,
    output int         checks,
    output int         errors
);
    timeunit 1ns;
    timeprecision 100ps;

    int test_checks;
    int test_errors;

    function automatic string reg_name(input logic [1:0] adr);
        case (adr)
            2'd0:    return "wb_dat_r(ADDR_LO)";
            2'd1:    return "wb_dat_r(ADDR_HI)";
            2'd2:    return "wb_dat_r(DATA)";
            default: return "wb_dat_r(CTRL)";
        endcase
    endfunction

    initial
    begin
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
    end

    always @(posedge CLK)
    begin
        if (!RESET && wb_ack && !wb_we && exp_en)
        begin
            checks      = checks + 1;
            test_checks = test_checks + 1;
            if ((wb_dat_r & exp_mask) !== exp_data)
            begin
                errors      = errors + 1;
                test_errors = test_errors + 1;
                $display("mismatch at %0d ns: %s expected %02h actual %02h",
                         $time, reg_name(wb_adr), exp_data, wb_dat_r & exp_mask);
            end
        end
        if (test_end)
        begin
            $display("test %0d done: %0d checks, %0d errors", test_id, test_checks,
                     test_errors);
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// File: verif/ee_sva.sv
`default_nettype none

module ee_sva
    import ee_bus_pkg::*;
(
    input logic     CLK,
    input logic     RESET,
    input logic     scl,
    input logic     sda_o,
    input logic     wb_cyc,
    input logic     wb_stb,
    input logic     wb_ack,
    input logic     busy,
    input logic     done,
    input bit_cmd_t cmd
);
    timeunit 1ns;
    timeprecision 100ps;

    // data may only move with scl low, start and stop excepted
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_o) && $past(scl) && scl) |-> (cmd == CMD_START || cmd == CMD_STOP))
        else $error("sda changed while scl high outside start or stop");

    // master holds the request, ack due one cycle later
    ack_next: assert property (@(posedge CLK) disable iff (RESET)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else $error("wb_ack missing on the cycle after cyc and stb");

    busy_end: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> $past(done))
        else $error("busy fell without done");

endmodule

bind ee_ctrl_top ee_sva i_ee_sva (
    .CLK    (CLK),
    .RESET  (RESET),
    .scl    (scl),
    .sda_o  (sda_o),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .busy   (busy),
    .done   (done),
    .cmd    (cmd)
);

`default_nettype wire

// File: verif/ee_tb.sv
`include "eeprom_defines.svh"
`default_nettype none

module ee_tb
    import ee_reg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 4;
    localparam int N_TRANS     = 48;
    localparam int READ_CYCLES = 180;   // worst-case random read incl. gaps
    localparam int POLL_MAX    = READ_CYCLES;

    logic       CLK;
    logic       RESET;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [1:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic       scl;
    logic       sda_o;
    logic       sda_oe;
    logic       sda;
    logic       model_low;
    logic       present;
    logic       exp_en;
    logic [7:0] exp_data;
    logic [7:0] exp_mask;
    logic       test_end;
    int         test_id;
    int         checks;
    int         errors;
    int         other_errors;
    int         seed;
    int         r;
    logic [7:0] ref_mem [0:2047];

    // wired-and with pull-up
    assign sda = (sda_oe ? sda_o : 1'b1) & ~model_low;

    ee_ctrl_top i_ee_ctrl_top (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_o    (sda_o),
        .sda_oe   (sda_oe),
        .sda_i    (sda)
    );

    ee_mem_model i_ee_mem_model (
        .scl     (scl),
        .sda     (sda),
        .present (present),
        .sda_low (model_low)
    );

    ee_checker i_ee_checker (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .exp_en   (exp_en),
        .exp_data (exp_data),
        .exp_mask (exp_mask),
        .test_id  (test_id),
        .test_end (test_end),
        .checks   (checks),
        .errors   (errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    initial
    begin
        #(N_TRANS * READ_CYCLES * CLK_NS * 2);
        $display("watchdog timeout, the run did not finish in time");
        $display("test failed");
        $finish;
    end

    function automatic logic [7:0] status_val(input logic b, input logic d, input logic n);
        logic [7:0] v;
        v       = '0;
        v[BUSY] = b;
        v[DONE] = d;
        v[NACK] = n;
        return v;
    endfunction

    task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
        @(posedge CLK);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge CLK);
        while (!wb_ack)
            @(negedge CLK);
        @(posedge CLK);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
        @(posedge CLK);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge CLK);
        while (!wb_ack)
            @(negedge CLK);
        dat = wb_dat_r;
        @(posedge CLK);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic expect_read(input logic [1:0] adr, input logic [7:0] val,
                               input logic [7:0] mask);
        logic [7:0] dummy;
        exp_en   = 1'b1;
        exp_data = val & mask;
        exp_mask = mask;
        wb_read(adr, dummy);
        exp_en = 1'b0;
    endtask

    task automatic wait_done();
        logic [7:0] st;
        int n;
        n = 0;
        do
        begin
            wb_read(`EE_REG_CTRL, st);
            n++;
        end while (!(st[DONE] && !st[BUSY]) && n < POLL_MAX);
        if (!(st[DONE] && !st[BUSY]))
        begin
            other_errors++;
            $display("transaction did not complete within %0d status polls", POLL_MAX);
        end
    endtask

    task automatic run_xfer(input logic is_rd, input logic [10:0] addr,
                            input logic [7:0] data, input logic exp_nack);
        logic [7:0] go;
        go = '0;
        if (is_rd)
            go[GO_READ] = 1'b1;
        else
            go[GO_WRITE] = 1'b1;
        wb_write(`EE_REG_ADDR_LO, addr[7:0]);
        wb_write(`EE_REG_ADDR_HI, {5'b0, addr[10:8]});
        if (!is_rd)
            wb_write(`EE_REG_DATA, data);
        wb_write(`EE_REG_CTRL, go);
        wait_done();
        expect_read(`EE_REG_CTRL, status_val(1'b0, 1'b1, exp_nack), 8'h07);
        if (!is_rd && present)
            ref_mem[addr] = data;
        if (is_rd && !exp_nack)
            expect_read(`EE_REG_DATA, ref_mem[addr], 8'hff);
    endtask

    task automatic end_test();
        @(posedge CLK);
        #1;
        test_end = 1'b1;
        @(posedge CLK);
        #1;
        test_end = 1'b0;
        test_id++;
    endtask

    initial
    begin
        logic [10:0] a;
        logic [7:0]  d;
        RESET        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        present      = 1'b1;
        exp_en       = 1'b0;
        exp_data     = '0;
        exp_mask     = '0;
        test_end     = 1'b0;
        test_id      = 1;
        other_errors = 0;
        seed         = 25;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hff;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;

        // register readback
        for (int k = 0; k < 8; k++)
        begin
            r = $random(seed);
            wb_write(`EE_REG_ADDR_LO, r[7:0]);
            wb_write(`EE_REG_ADDR_HI, r[15:8]);
            wb_write(`EE_REG_DATA, r[23:16]);
            expect_read(`EE_REG_ADDR_LO, r[7:0], 8'hff);
            expect_read(`EE_REG_ADDR_HI, {5'b0, r[10:8]}, 8'hff);
            expect_read(`EE_REG_DATA, r[23:16], 8'hff);
        end
        end_test();

        r = $random(seed);
        run_xfer(1'b0, r[10:0], r[18:11], 1'b0);
        run_xfer(1'b1, r[10:0], 8'h00, 1'b0);
        end_test();

        // small pool half the time so reads hit written bytes
        for (int k = 0; k < 40; k++)
        begin
            r = $random(seed);
            a = r[19] ? r[10:0] : {r[10:8], 5'b0, r[2:0]};
            if (r[31])
                run_xfer(1'b1, a, 8'h00, 1'b0);
            else
                run_xfer(1'b0, a, r[27:20], 1'b0);
        end
        end_test();

        r = $random(seed);
        a = r[10:0];
        present = 1'b0;
        run_xfer(1'b0, a, ~ref_mem[a], 1'b1);
        run_xfer(1'b1, a, 8'h00, 1'b1);
        present = 1'b1;
        run_xfer(1'b1, a, 8'h00, 1'b0);
        end_test();

        // second go lands while busy and must be dropped
        r = $random(seed);
        a = r[10:0];
        d = r[18:11];
        wb_write(`EE_REG_ADDR_LO, a[7:0]);
        wb_write(`EE_REG_ADDR_HI, {5'b0, a[10:8]});
        wb_write(`EE_REG_DATA, d);
        wb_write(`EE_REG_CTRL, 8'h01);
        wb_write(`EE_REG_ADDR_LO, a[7:0] ^ 8'h5a);
        wb_write(`EE_REG_DATA, ~d);
        wb_write(`EE_REG_CTRL, 8'h01);
        wait_done();
        ref_mem[a] = d;
        repeat (40)
            expect_read(`EE_REG_CTRL, status_val(1'b0, 1'b1, 1'b0), 8'h07);
        run_xfer(1'b1, a, 8'h00, 1'b0);
        run_xfer(1'b1, {a[10:8], a[7:0] ^ 8'h5a}, 8'h00, 1'b0);
        end_test();

        $display("total: %0d checks, %0d errors", checks, errors + other_errors);
        if (errors + other_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/ee_bus_pkg.sv
hdl/ee_reg_pkg.sv
hdl/ee_regs.sv
hdl/ee_xfer_seq.sv
hdl/ee_bit_engine.sv
hdl/ee_ctrl_top.sv
verif/ee_mem_model.sv
verif/ee_checker.sv
verif/ee_sva.sv
verif/ee_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the EEPROM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module ee_tb \
    -f filelist.f -o ee_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/ee_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
